//--- etx_clocks.f
rtl/etx_cfg_pkg.sv
rtl/etx_seq_pkg.sv
rtl/etx_heartbeat_timer.sv
rtl/etx_lock_monitor.sv
rtl/etx_reset_sequencer.sv
rtl/etx_clocks.sv
verif/etx_clocks_asserts.sv
verif/etx_clocks_tb.sv

//--- verif/etx_clocks_tb.sv
`timescale 1ns/10ps

module etx_clocks_tb;

   import etx_cfg_pkg::*;
   import etx_seq_pkg::*;

   localparam int HB_PERIOD = 2 ** RCW;
   localparam int HIST_W    = SYNC_STAGES + LOCK_FILTER;   // lock sample history

   // pin patterns in pll chip etx io active order
   localparam reset_out_t OUT_RESET_ALL = 5'b10110;
   localparam reset_out_t OUT_START     = 5'b00110;
   localparam reset_out_t OUT_HOLD      = 5'b01110;
   localparam reset_out_t M_PLL_CHIP    = 5'b11000;
   localparam reset_out_t M_ETX         = 5'b00100;
   localparam reset_out_t M_IO          = 5'b00010;
   localparam reset_out_t M_ACT         = 5'b00001;

   logic sys_clk;
   logic tx_reset;
   logic soft_reset;
   logic pll_locked;
   logic pll_reset;
   logic chip_resetb;
   logic etx_reset;
   logic etx_io_reset;
   logic tx_active;
   logic lclk_div4_en;

   logic [31:0] rng;        // xorshift state
   int          value_errs;
   int          timeouts;

   // cycle model state
   int                cyc;         // edges since reset release
   reset_state_t      m_state;
   reset_state_t      m_nxt;
   logic              m_hb;
   logic              m_div;
   logic [HIST_W-1:0] m_hist;      // pll_locked samples with bit 0 newest
   logic              m_locked;
   logic              m_lost;
   int                m_act_cyc;   // cycles held in ACTIVE
   int                m_act_div;   // div4 edges held in ACTIVE

   etx_clocks UUT
   (
      .sys_clk      (sys_clk),
      .tx_reset     (tx_reset),
      .soft_reset   (soft_reset),
      .pll_locked   (pll_locked),
      .pll_reset    (pll_reset),
      .chip_resetb  (chip_resetb),
      .etx_reset    (etx_reset),
      .etx_io_reset (etx_io_reset),
      .tx_active    (tx_active),
      .lclk_div4_en (lclk_div4_en)
   );

   initial
   begin
      sys_clk = 1'b0;
      forever #4 sys_clk = ~sys_clk;   // 8 ns
   end

   //######################################################################
   // reference model
   //######################################################################

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   task automatic pick(input int lo, input int hi, output int v);
      rng = xorshift32(rng);
      v   = lo + int'(rng % (hi - lo + 1));
   endtask

   function automatic reset_state_t next_state(input reset_state_t s, input logic hb,
                                               input logic soft_req, input logic locked,
                                               input logic lost);
      // lock loss once the chip is up skips the heartbeat
      if (lost && (s == DEASSERT_RESET || s == HOLD_IT || s == ACTIVE))
      begin
         return RESET_ALL;
      end
      if (!hb)
      begin
         return s;
      end
      case (s)
         RESET_ALL:      return soft_req ? RESET_ALL : START_CCLK;
         START_CCLK:     return locked ? STOP_CCLK : START_CCLK;
         STOP_CCLK:      return DEASSERT_RESET;
         DEASSERT_RESET: return HOLD_IT;
         HOLD_IT:        return locked ? ACTIVE : HOLD_IT;
         ACTIVE:         return soft_req ? RESET_ALL : ACTIVE;
         default:        return RESET_ALL;
      endcase
   endfunction

   function automatic reset_out_t expected_outputs();
      reset_out_t e;
      e.pll_reset    = (m_state == RESET_ALL) || (m_state == STOP_CCLK) ||
                       (m_state == DEASSERT_RESET);
      e.chip_resetb  = (m_state == DEASSERT_RESET) || (m_state == HOLD_IT) ||
                       (m_state == ACTIVE);
      e.tx_active    = (m_state == ACTIVE);
      e.etx_io_reset = !(e.tx_active && m_act_cyc >= RELEASE_STAGES);   // 2 cycles in
      e.etx_reset    = !(e.tx_active && m_act_div >= RELEASE_STAGES);   // 2nd div4 edge
      return e;
   endfunction

   function automatic reset_out_t dut_outputs();
      reset_out_t a;
      a.pll_reset    = pll_reset;
      a.chip_resetb  = chip_resetb;
      a.etx_reset    = etx_reset;
      a.etx_io_reset = etx_io_reset;
      a.tx_active    = tx_active;
      return a;
   endfunction

   // model steps on the edge where inputs are stable
   always @(posedge sys_clk or posedge tx_reset)
   begin
      if (tx_reset)
      begin
         cyc       = 0;
         m_state   = RESET_ALL;
         m_hb      = 1'b0;
         m_div     = 1'b0;
         m_hist    = '0;
         m_locked  = 1'b0;
         m_lost    = 1'b0;
         m_act_cyc = 0;
         m_act_div = 0;
      end
      else
      begin
         m_nxt = next_state(m_state, m_hb, soft_reset, m_locked, m_lost);
         if (m_state == ACTIVE && m_nxt == ACTIVE)
         begin
            m_act_cyc = m_act_cyc + 1;
            m_act_div = m_act_div + int'(m_div);
         end
         else
         begin
            m_act_cyc = 0;   // any exit re-asserts both
            m_act_div = 0;
         end
         // lock needs LOCK_FILTER high samples seen through the sync delay
         m_hist   = {m_hist[HIST_W-2:0], pll_locked};
         m_lost   = m_locked && !(&m_hist[HIST_W-1:SYNC_STAGES]);
         m_locked = &m_hist[HIST_W-1:SYNC_STAGES];
         cyc      = cyc + 1;
         m_hb     = (cyc % HB_PERIOD) == 0;
         m_div    = (cyc % LCLK_DIV) == 0;
         m_state  = m_nxt;
      end
   end

   //######################################################################
   // checks
   //######################################################################

   task automatic check_reset_out(input reset_out_t exp, input reset_out_t act,
                                  input string what);
      if (act !== exp)
      begin
         value_errs++;
         $display("[ERROR] t=%0d ns %s: outputs %b, expected %b", $time, what, act, exp);
      end
   endtask

   task automatic check_div4(input logic exp, input logic act, input string what);
      if (act !== exp)
      begin
         value_errs++;
         $display("[ERROR] t=%0d ns %s: got %b, expected %b", $time, what, act, exp);
      end
   endtask

   task automatic check_gap(input int exp, input int act, input string what);
      if (act != exp)
      begin
         value_errs++;
         $display("[ERROR] t=%0d ns %s: %0d cycles, expected %0d", $time, what, act, exp);
      end
   endtask

   // compare at the falling edge when everything has settled
   always @(negedge sys_clk)
   begin
      check_reset_out(expected_outputs(), dut_outputs(), "cycle model");
      check_div4(m_div, lclk_div4_en, "lclk_div4_en");
   end

   //######################################################################
   // stimulus helpers
   //######################################################################

   task automatic step_cycles(input int n);
      repeat (n) @(posedge sys_clk);
      #1;   // drive point
   endtask

   task automatic wait_pins(input reset_out_t want, input reset_out_t mask, input int limit,
                            input string what, output int at);
      int n;
      at = -1;
      n  = 0;
      while (at < 0 && n < limit)
      begin
         @(negedge sys_clk);
         n++;
         if (((dut_outputs() ^ want) & mask) == '0)
         begin
            at = cyc;   // edge that made the change
         end
      end
      if (at < 0)
      begin
         timeouts++;
         $display("timeout: %s not seen within %0d cycles", what, limit);
      end
   endtask

   task automatic wait_div4(input int limit, output int at);
      int n;
      at = -1;
      n  = 0;
      while (at < 0 && n < limit)
      begin
         @(negedge sys_clk);
         n++;
         if (lclk_div4_en === 1'b1)
         begin
            at = cyc;
         end
      end
      if (at < 0)
      begin
         timeouts++;
         $display("timeout: lclk_div4_en never pulsed within %0d cycles", limit);
      end
   endtask

   // high runs shorter than the filter with low gaps that restart it
   task automatic glitch_burst(input int count, input reset_out_t hold_out, input string where);
      int hi;
      int lo;
      repeat (count)
      begin
         pick(1, LOCK_FILTER - 1, hi);
         pick(2, 9, lo);
         pll_locked = 1'b1;
         step_cycles(hi);
         pll_locked = 1'b0;
         step_cycles(lo);
         check_reset_out(hold_out, dut_outputs(), where);
      end
   endtask

   //######################################################################
   // test sequence
   //######################################################################

   initial
   begin
      int t [0:5];
      int hold;
      int td;
      rng        = 32'ha15789cf;
      value_errs = 0;
      timeouts   = 0;
      tx_reset   = 1'b1;
      soft_reset = 1'b1;
      pll_locked = 1'b1;
      repeat (8) @(posedge sys_clk);
      #1 tx_reset = 1'b0;

      wait_div4(2 * LCLK_DIV, t[0]);
      check_gap(LCLK_DIV, t[0], "first lclk_div4_en");

      // soft_reset parks the sequence
      pick(2, 4, hold);
      repeat (hold * HB_PERIOD)
      begin
         step_cycles(1);
         check_reset_out(OUT_RESET_ALL, dut_outputs(), "soft_reset hold");
      end
      soft_reset = 1'b0;

      // power-up walk with lock stable
      wait_pins(5'b00000, M_PLL_CHIP, 2 * HB_PERIOD, "START_CCLK", t[0]);
      wait_pins(5'b10000, M_PLL_CHIP, 2 * HB_PERIOD, "STOP_CCLK", t[1]);
      wait_pins(5'b11000, M_PLL_CHIP, 2 * HB_PERIOD, "DEASSERT_RESET", t[2]);
      wait_pins(5'b01000, M_PLL_CHIP, 2 * HB_PERIOD, "HOLD_IT", t[3]);
      wait_pins(5'b00001, M_ACT, 2 * HB_PERIOD, "ACTIVE", t[4]);
      for (int i = 1; i < 5; i++)
         check_gap(HB_PERIOD, t[i] - t[i-1], "state spacing");

      wait_pins(5'b00000, M_IO, 8, "etx_io_reset release", t[5]);
      check_gap(RELEASE_STAGES, t[5] - t[4], "etx_io_reset release");
      wait_pins(5'b00000, M_ETX, 4 * LCLK_DIV, "etx_reset release", t[5]);
      check_gap(RELEASE_STAGES * LCLK_DIV, t[5] - t[4], "etx_reset release");

      // soft_reset out of ACTIVE exits on the heartbeat edge
      pick(1, 2 * HB_PERIOD, hold);
      step_cycles(hold);
      soft_reset = 1'b1;
      wait_pins(5'b00000, M_ACT, 2 * HB_PERIOD, "exit ACTIVE on soft_reset", t[0]);
      check_reset_out(OUT_RESET_ALL, dut_outputs(), "soft_reset exit");
      check_gap(1, t[0] % HB_PERIOD, "soft_reset exit edge");
      step_cycles(1);
      pll_locked = 1'b0;
      pick(2, 4, hold);
      step_cycles(hold * HB_PERIOD);
      check_reset_out(OUT_RESET_ALL, dut_outputs(), "soft_reset parked");
      soft_reset = 1'b0;

      // short lock glitches in both lock wait states
      wait_pins(5'b00000, M_PLL_CHIP, 2 * HB_PERIOD, "START_CCLK again", t[0]);
      step_cycles(1);
      glitch_burst(12, OUT_START, "glitch in START_CCLK");
      pll_locked = 1'b1;
      wait_pins(5'b10000, M_PLL_CHIP, 2 * HB_PERIOD, "STOP_CCLK after glitches", t[1]);
      step_cycles(1);
      pll_locked = 1'b0;   // loss inside STOP_CCLK is ignored
      wait_pins(5'b11000, M_PLL_CHIP, 2 * HB_PERIOD, "DEASSERT_RESET again", t[2]);
      wait_pins(5'b01000, M_PLL_CHIP, 2 * HB_PERIOD, "HOLD_IT again", t[3]);
      step_cycles(1);
      glitch_burst(12, OUT_HOLD, "glitch in HOLD_IT");
      pll_locked = 1'b1;
      wait_pins(5'b00001, M_ACT, 2 * HB_PERIOD, "ACTIVE after glitches", t[4]);

      // lock loss in ACTIVE gives the lost pulse and then the state edge
      step_cycles(4);
      td         = cyc;
      pll_locked = 1'b0;
      wait_pins(5'b00000, M_ACT, 4 * SYNC_STAGES, "exit ACTIVE on lock loss", t[0]);
      check_gap(SYNC_STAGES + 2, t[0] - td, "lock loss to RESET_ALL");
      step_cycles(1);
      pll_locked = 1'b1;
      wait_pins(5'b00001, M_ACT, 8 * HB_PERIOD, "ACTIVE after lock loss", t[1]);
      step_cycles(2 * HB_PERIOD);

      $display("errors: %0d value mismatches, %0d timeouts", value_errs, timeouts);
      if (value_errs == 0 && timeouts == 0)
      begin
         $display("test passed");
      end
      else
      begin
         $display("test failed");
      end
      $finish;
   end

endmodule : etx_clocks_tb

//--- verif/etx_clocks_asserts.sv
`timescale 1ns/10ps

module etx_clocks_asserts
(
   input logic sys_clk,
   input logic tx_reset,
   input logic pll_reset,
   input logic chip_resetb,
   input logic etx_io_reset,
   input logic tx_active,
   input logic lclk_div4_en
);

   import etx_cfg_pkg::*;

   // chip leaves reset only out of STOP_CCLK, pll still held
   chip_release_a : assert property (@(posedge sys_clk) disable iff (tx_reset)
      $rose(chip_resetb) |-> (pll_reset && $past(pll_reset)))
      else $error("chip_resetb released while the pll was running");

   // io stays in reset outside ACTIVE
   io_reset_a : assert property (@(posedge sys_clk) disable iff (tx_reset)
      !tx_active |-> etx_io_reset)
      else $error("etx_io_reset low while tx_active low");

   // fixed slow enable period
   div4_period_a : assert property (@(posedge sys_clk) disable iff (tx_reset)
      lclk_div4_en |-> ##1 (!lclk_div4_en [*LCLK_DIV-1]) ##1 lclk_div4_en)
      else $error("lclk_div4_en period broken");

endmodule : etx_clocks_asserts

bind etx_clocks etx_clocks_asserts u_asserts
(
   .sys_clk      (sys_clk),
   .tx_reset     (tx_reset),
   .pll_reset    (pll_reset),
   .chip_resetb  (chip_resetb),
   .etx_io_reset (etx_io_reset),
   .tx_active    (tx_active),
   .lclk_div4_en (lclk_div4_en)
);

//--- rtl/etx_clocks.sv
`timescale 1ns/10ps

module etx_clocks
(
   input  logic sys_clk,        // always on
   input  logic tx_reset,       // async power-on reset, active high
   input  logic soft_reset,     // software hold
   input  logic pll_locked,     // external pll lock flag
   output logic pll_reset,      // to external pll
   output logic chip_resetb,    // chip reset, active low
   output logic etx_reset,      // tx core logic reset
   output logic etx_io_reset,   // tx io reset
   output logic tx_active,      // link usable
   output logic lclk_div4_en    // slow logic enable
);

   import etx_seq_pkg::*;

   pace_t        pace;
   lock_status_t lock;
   reset_out_t   rst_out;

   //######################################################################
   // pacing and lock
   //######################################################################

   etx_heartbeat_timer u_heartbeat_timer
   (
      .sys_clk    (sys_clk),
      .tx_reset   (tx_reset),
      .pace       (pace)
   );

   etx_lock_monitor u_lock_monitor
   (
      .sys_clk    (sys_clk),
      .tx_reset   (tx_reset),
      .pll_locked (pll_locked),
      .lock       (lock)
   );

   //######################################################################
   // sequencer
   //######################################################################

   etx_reset_sequencer u_reset_sequencer
   (
      .sys_clk    (sys_clk),
      .tx_reset   (tx_reset),
      .soft_reset (soft_reset),
      .pace       (pace),
      .lock       (lock),
      .rst_out    (rst_out)
   );

   // flatten the reset bundle onto the pins
   assign pll_reset    = rst_out.pll_reset;
   assign chip_resetb  = rst_out.chip_resetb;
   assign etx_reset    = rst_out.etx_reset;
   assign etx_io_reset = rst_out.etx_io_reset;
   assign tx_active    = rst_out.tx_active;
   assign lclk_div4_en = pace.div4_en;   // stands in for the slow clock

endmodule : etx_clocks

//--- rtl/etx_reset_sequencer.sv
`timescale 1ns/10ps

module etx_reset_sequencer
(
   input  logic                      sys_clk,
   input  logic                      tx_reset,     // async, active high
   input  logic                      soft_reset,   // software hold
   input  etx_seq_pkg::pace_t        pace,
   input  etx_seq_pkg::lock_status_t lock,
   output etx_seq_pkg::reset_out_t   rst_out
);

   import etx_cfg_pkg::*;
   import etx_seq_pkg::*;

   reset_state_t              state;
   reset_state_t              state_nxt;
   logic                      chip_up;      // chip reset released
   logic                      is_active;
   logic                      rel_clr;      // async assert for both pipes
   logic [RELEASE_STAGES-1:0] io_rel_b;     // io release pipe, active low
   logic [RELEASE_STAGES-1:0] core_rel_b;   // core release pipe, active low

   //######################################################################
   // state machine
   //######################################################################

   // lock loss only matters once the chip is out of reset
   assign chip_up = (state == DEASSERT_RESET) ||
                    (state == HOLD_IT)        ||
                    (state == ACTIVE);

   always_comb
   begin
      state_nxt = state;
      if (lock.lock_lost && chip_up)
      begin
         state_nxt = RESET_ALL;   // no wait for the heartbeat
      end
      else if (pace.heartbeat)
      begin
         case (state)
            RESET_ALL:
            begin
               if (!soft_reset)
               begin
                  state_nxt = START_CCLK;
               end
            end
            START_CCLK:
            begin
               if (lock.locked)
               begin
                  state_nxt = STOP_CCLK;
               end
            end
            STOP_CCLK:      state_nxt = DEASSERT_RESET;
            DEASSERT_RESET: state_nxt = HOLD_IT;
            HOLD_IT:
            begin
               if (lock.locked)
               begin
                  state_nxt = ACTIVE;
               end
            end
            ACTIVE:
            begin
               if (soft_reset)
               begin
                  state_nxt = RESET_ALL;   // parked until soft_reset drops
               end
            end
            default:        state_nxt = RESET_ALL;   // unused codes recover
         endcase
      end
   end

   always_ff @(posedge sys_clk or posedge tx_reset)
   begin
      if (tx_reset)
      begin
         state <= RESET_ALL;
      end
      else
      begin
         state <= state_nxt;
      end
   end

   assign is_active = (state == ACTIVE);

   //######################################################################
   // release pipes, async assert and sync release
   //######################################################################

   // both pipes clear the moment the state leaves ACTIVE
   assign rel_clr = tx_reset || !is_active;

   // io pipe shifts every cycle
   always_ff @(posedge sys_clk or posedge rel_clr)
   begin
      if (rel_clr)
      begin
         io_rel_b <= '0;
      end
      else
      begin
         io_rel_b <= {io_rel_b[RELEASE_STAGES-2:0], 1'b1};
      end
   end

   // core pipe follows the slow logic enable
   always_ff @(posedge sys_clk or posedge rel_clr)
   begin
      if (rel_clr)
      begin
         core_rel_b <= '0;
      end
      else if (pace.div4_en)
      begin
         core_rel_b <= {core_rel_b[RELEASE_STAGES-2:0], 1'b1};
      end
   end

   //######################################################################
   // output decode
   //######################################################################

   always_comb
   begin
      rst_out.pll_reset    = (state == RESET_ALL)  ||
                             (state == STOP_CCLK)  ||
                             (state == DEASSERT_RESET);   // pll held
      rst_out.chip_resetb  = chip_up;
      rst_out.etx_reset    = !core_rel_b[RELEASE_STAGES-1];
      rst_out.etx_io_reset = !io_rel_b[RELEASE_STAGES-1];
      rst_out.tx_active    = is_active;
   end

endmodule : etx_reset_sequencer

//--- rtl/etx_lock_monitor.sv
`timescale 1ns/10ps

module etx_lock_monitor
(
   input  logic                      sys_clk,
   input  logic                      tx_reset,     // async, active high
   input  logic                      pll_locked,   // async from the pll
   output etx_seq_pkg::lock_status_t lock
);

   import etx_cfg_pkg::*;
   import etx_seq_pkg::*;

   logic [SYNC_STAGES-1:0] lock_sync;   // synchronizer chain
   logic                   sync_lvl;    // synchronized lock flag
   logic [LOCK_CNT_W-1:0]  good_cnt;    // consecutive high samples
   logic                   lock_hit;    // filter satisfied this sample
   logic                   locked_q;
   logic                   lost_q;

   //######################################################################
   // synchronizer
   //######################################################################

   always_ff @(posedge sys_clk or posedge tx_reset)
   begin
      if (tx_reset)
      begin
         lock_sync <= '0;
      end
      else
      begin
         lock_sync <= {lock_sync[SYNC_STAGES-2:0], pll_locked};
      end
   end

   assign sync_lvl = lock_sync[SYNC_STAGES-1];

   //######################################################################
   // filter
   //######################################################################

   // last needed sample arrives with the counter saturated
   assign lock_hit = sync_lvl && (good_cnt == LOCK_CNT_W'(LOCK_FILTER - 1));

   always_ff @(posedge sys_clk or posedge tx_reset)
   begin
      if (tx_reset)
      begin
         good_cnt <= '0;
      end
      else if (!sync_lvl)
      begin
         good_cnt <= '0;              // any low sample restarts the count
      end
      else if (good_cnt != LOCK_CNT_W'(LOCK_FILTER - 1))
      begin
         good_cnt <= good_cnt + 1'b1;   // saturating
      end
   end

   // lock drops on the first low sample, no filtering on the way down
   always_ff @(posedge sys_clk or posedge tx_reset)
   begin
      if (tx_reset)
      begin
         locked_q <= 1'b0;
         lost_q   <= 1'b0;
      end
      else
      begin
         locked_q <= lock_hit;
         lost_q   <= locked_q && !lock_hit;   // falling edge of locked
      end
   end

   assign lock.locked    = locked_q;
   assign lock.lock_lost = lost_q;

endmodule : etx_lock_monitor

//--- rtl/etx_heartbeat_timer.sv
`timescale 1ns/10ps

module etx_heartbeat_timer
(
   input  logic               sys_clk,
   input  logic               tx_reset,   // async, active high
   output etx_seq_pkg::pace_t pace
);

   import etx_cfg_pkg::*;
   import etx_seq_pkg::*;

   logic [RCW-1:0] rc_cnt;   // free running wrap counter
   logic           hb_q;
   logic           div_q;

   //######################################################################
   // wrap counter
   //######################################################################

   always_ff @(posedge sys_clk or posedge tx_reset)
   begin
      if (tx_reset)
      begin
         rc_cnt <= '0;
      end
      else
      begin
         rc_cnt <= rc_cnt + 1'b1;   // wraps at 2**RCW
      end
   end

   // strobes registered one cycle after the decode
   always_ff @(posedge sys_clk or posedge tx_reset)
   begin
      if (tx_reset)
      begin
         hb_q  <= 1'b0;
         div_q <= 1'b0;
      end
      else
      begin
         hb_q  <= &rc_cnt;                                          // all ones
         div_q <= (rc_cnt[LCLK_W-1:0] == LCLK_W'(LCLK_DIV - 1));   // low bits wrap
      end
   end

   // a heartbeat cycle is always a div4 cycle too
   assign pace.heartbeat = hb_q;
   assign pace.div4_en   = div_q;

endmodule : etx_heartbeat_timer

//--- rtl/etx_seq_pkg.sv
//######################################################################
// sequencer state and the structs passed between blocks
//######################################################################

package etx_seq_pkg;

   // power-up sequence, encoding kept from the old define list
   typedef enum logic [2:0]
   {
      RESET_ALL      = 3'b000,   // everything held, pll in reset
      START_CCLK     = 3'b001,   // pll running, wait for lock
      STOP_CCLK      = 3'b010,   // pll back in reset
      DEASSERT_RESET = 3'b011,   // chip reset released
      HOLD_IT        = 3'b100,   // pll running again, wait for lock
      ACTIVE         = 3'b101    // link enabled
   } reset_state_t;

   // pacing strobes from the heartbeat timer
   typedef struct packed
   {
      logic heartbeat;   // one cycle every 2**RCW
      logic div4_en;     // slow logic enable
   } pace_t;

   // filtered pll lock
   typedef struct packed
   {
      logic locked;      // level
      logic lock_lost;   // pulse on falling locked
   } lock_status_t;

   // sequencer outputs
   typedef struct packed
   {
      logic pll_reset;      // to external pll
      logic chip_resetb;    // chip reset, active low
      logic etx_reset;      // tx core logic reset
      logic etx_io_reset;   // tx io reset
      logic tx_active;      // link usable
   } reset_out_t;

endpackage : etx_seq_pkg

//--- rtl/etx_cfg_pkg.sv
//######################################################################
// sequencer timing constants
//######################################################################

package etx_cfg_pkg;

   // heartbeat counter width, period is 2**RCW sys_clk cycles
   localparam int RCW            = 4;

   // high lock samples needed before lock is reported
   localparam int LOCK_FILTER    = 4;

   // period of the slow logic enable
   localparam int LCLK_DIV       = 4;

   // lock flag synchronizer depth
   localparam int SYNC_STAGES    = 2;

   // flops in each reset release pipe
   localparam int RELEASE_STAGES = 2;

   // derived widths
   localparam int LOCK_CNT_W     = $clog2(LOCK_FILTER);   // filter count 0..LOCK_FILTER-1
   localparam int LCLK_W         = $clog2(LCLK_DIV);      // low counter bits for div enable

endpackage : etx_cfg_pkg
